//--- hdl/byte_fifo.sv
// byte fifo: circular buffer with registered read data, empty flag and occupancy count

`timescale 1ns/1ps

module byte_fifo (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              wr_en_i,     // push wr_data_i
    input  usb_tx_pkg::byte_t                 wr_data_i,   // byte to push
    input  logic                              rd_strobe_i, // pop head into rd_data_o
    output usb_tx_pkg::byte_t                 rd_data_o,   // last popped byte
    output logic                              not_empty_o, // at least one byte stored
    output logic [usb_tx_pkg::FIFO_CNT_W-1:0] count_o      // bytes stored
);

    import usb_tx_pkg::*;

    //////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////

    byte_t                 mem_q [FIFO_DEPTH];  // byte storage
    logic [FIFO_PTR_W-1:0] wr_ptr_q;            // next slot to write
    logic [FIFO_PTR_W-1:0] rd_ptr_q;            // head slot
    logic [FIFO_CNT_W-1:0] count_q;             // occupancy
    logic                  do_wr;               // qualified push
    logic                  do_rd;               // qualified pop
    logic                  full;
    logic                  empty;

    assign full  = count_q == FIFO_CNT_W'(FIFO_DEPTH);
    assign empty = count_q == '0;
    assign do_wr = wr_en_i && !full;            // a full fifo ignores writes
    assign do_rd = rd_strobe_i && !empty;       // an empty fifo ignores pops

    assign not_empty_o = !empty;
    assign count_o     = count_q;

    //////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(1);  // wraps at depth
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + FIFO_CNT_W'(1);
                2'b01:   count_q <= count_q - FIFO_CNT_W'(1);
                default: count_q <= count_q;            // both or neither
            endcase
        end
    end

    //////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
        if (do_rd) begin
            rd_data_o <= mem_q[rd_ptr_q];   // holds until the next pop
        end
    end

endmodule

//--- hdl/fx2_usb_pipe.sv
// fx2 write pipe: state machine moving fifo bytes onto the fx2 slave fifo write port

`timescale 1ns/1ps

module fx2_usb_pipe (
    input  logic              clk_i,          // fx2 interface clock
    input  logic              rst_n_i,
    input  usb_tx_pkg::byte_t data_i,         // byte from the fifo read register
    input  logic              data_avail_i,   // fifo not empty
    output logic              read_strobe_o,  // pops one fifo byte
    input  logic              ready_i,        // endpoint has room
    output logic              slwr_n_o,       // fx2 write strobe, active low
    output usb_tx_pkg::byte_t fd_o,           // fx2 data bus, output side
    output logic              fd_oe_o         // pad buffer enable
);

    import usb_tx_pkg::*;

    logic [ST_W-1:0] state_q;     // current state
    logic            avail_q;     // registered data available level
    logic            write_now;   // byte taken by the fx2 this cycle

    //////////////////////////////////////////////////
    // fx2 bus drive
    //////////////////////////////////////////////////

    // strobe qualified by the live flag so a write never lands on a full endpoint
    assign write_now = (state_q == ST_WRITE) && ready_i;

    assign slwr_n_o = !write_now;
    assign fd_oe_o  = write_now;                    // bus driven only while writing
    assign fd_o     = write_now ? data_i : '0;      // quiet bus otherwise

    //////////////////////////////////////////////////
    // transfer state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= ST_IDLE;
            avail_q       <= 1'b0;
            read_strobe_o <= 1'b0;
        end else begin
            avail_q       <= data_avail_i;          // one register on the level
            read_strobe_o <= 1'b0;                  // strobe is a single pulse

            case (state_q)
                ST_IDLE: begin
                    if (avail_q) begin              // data waiting, pop it
                        read_strobe_o <= 1'b1;
                        state_q       <= ST_STROBE;
                    end
                end

                ST_STROBE: begin
                    state_q <= ST_HOLD;             // fifo pops at this edge
                end

                ST_HOLD: begin
                    state_q <= ST_WAIT;             // read register now valid
                end

                ST_WAIT: begin
                    if (ready_i) begin              // endpoint has room
                        state_q <= ST_WRITE;
                    end
                end

                ST_WRITE: begin
                    if (ready_i) begin
                        state_q <= ST_IDLE;         // byte taken, start over
                    end else begin
                        state_q <= ST_WAIT;         // flag dropped, keep waiting
                    end
                end

                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/sample_packer.sv
// sample packer: splits each 16 bit sample into two fifo writes, sticky overflow flag

`timescale 1ns/1ps

module sample_packer (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              sample_valid_i,  // single cycle strobe
    input  usb_tx_pkg::sample_u               sample_i,        // sample word
    input  logic [usb_tx_pkg::FIFO_CNT_W-1:0] fifo_count_i,    // fifo occupancy
    output logic                              fifo_wr_en_o,    // fifo write enable
    output usb_tx_pkg::byte_t                 fifo_wr_data_o,  // fifo write byte
    output logic                              overflow_o       // sample dropped, sticky
);

    import usb_tx_pkg::*;

    //////////////////////////////////////////////////
    // accept decision
    //////////////////////////////////////////////////

    logic  accept;       // strobe taken this cycle
    logic  refuse;       // strobe dropped this cycle
    logic  room_ok;      // two free bytes in the fifo
    logic  lo_pending_q; // low byte still to be written
    byte_t lo_byte_q;    // low byte held for the second write

    // count already includes every earlier write, strobes are two cycles apart
    assign room_ok = fifo_count_i <= FIFO_CNT_W'(FIFO_DEPTH - 2);
    assign accept  = sample_valid_i && room_ok && !lo_pending_q;
    assign refuse  = sample_valid_i && !accept;

    //////////////////////////////////////////////////
    // fifo write port
    //////////////////////////////////////////////////

    assign fifo_wr_en_o   = accept || lo_pending_q;                        // hi now, lo next
    assign fifo_wr_data_o = lo_pending_q ? lo_byte_q : sample_i.bytes.hi_byte;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lo_pending_q <= 1'b0;
            overflow_o   <= 1'b0;
        end else begin
            lo_pending_q <= accept;                    // one cycle after the hi byte
            if (refuse) begin
                overflow_o <= 1'b1;                    // held until reset
            end
        end
    end

    // low byte register, payload only
    always_ff @(posedge clk_i) begin
        if (accept) begin
            lo_byte_q <= sample_i.bytes.lo_byte;
        end
    end

endmodule

//--- hdl/usb_tx_pkg.sv
// shared types, widths, FIFO sizing and pipe state codes for the usb transmit path

package usb_tx_pkg;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    localparam int BYTE_W = 8;                      // fx2 data bus width

    typedef logic [BYTE_W-1:0] byte_t;              // one byte on the fx2 bus

    // a/d sample word, seen as a signed value or as two bus bytes
    typedef union packed {
        logic signed [2*BYTE_W-1:0] value;          // signed a/d sample
        struct packed {
            byte_t hi_byte;                         // sent first
            byte_t lo_byte;                         // sent second
        } bytes;
    } sample_u;

    //////////////////////////////////////////////////
    // fifo sizing
    //////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 16;                 // bytes held in the fifo
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH); // read/write pointer width
    localparam int FIFO_CNT_W = 5;                  // occupancy 0..FIFO_DEPTH

    // pipe state codes
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE   = 3'd0;   // wait for registered data level
    localparam logic [ST_W-1:0] ST_STROBE = 3'd1;   // read strobe high for one cycle
    localparam logic [ST_W-1:0] ST_HOLD   = 3'd2;   // read register settles
    localparam logic [ST_W-1:0] ST_WAIT   = 3'd3;   // wait for endpoint room
    localparam logic [ST_W-1:0] ST_WRITE  = 3'd4;   // slwr low, byte on the bus

endpackage

//--- hdl/usb_tx_top.sv
// transmit path top: sample packer, byte fifo and fx2 write pipe

`timescale 1ns/1ps

module usb_tx_top (
    input  logic                 clk_i,           // fx2 clock, whole design
    input  logic                 rst_n_i,
    input  logic                 sample_valid_i,  // a/d sample strobe
    input  usb_tx_pkg::sample_u  sample_i,        // signed a/d sample
    output logic                 overflow_o,      // a sample was dropped
    input  logic                 ready_i,         // fx2 endpoint room flag
    output logic                 slwr_n_o,        // fx2 write strobe
    output usb_tx_pkg::byte_t    fd_o,            // fx2 data out
    output logic                 fd_oe_o          // fx2 data output enable
);

    import usb_tx_pkg::*;

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////

    logic                  fifo_wr_en;      // packer push
    byte_t                 fifo_wr_data;    // packer byte
    logic [FIFO_CNT_W-1:0] fifo_count;      // fifo occupancy to packer
    logic                  fifo_rd_strobe;  // pipe pop
    byte_t                 fifo_rd_data;    // head byte to pipe
    logic                  fifo_not_empty;  // data level to pipe

    sample_packer u_packer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .fifo_count_i   (fifo_count),
        .fifo_wr_en_o   (fifo_wr_en),
        .fifo_wr_data_o (fifo_wr_data),
        .overflow_o     (overflow_o)
    );

    byte_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_en_i     (fifo_wr_en),
        .wr_data_i   (fifo_wr_data),
        .rd_strobe_i (fifo_rd_strobe),
        .rd_data_o   (fifo_rd_data),
        .not_empty_o (fifo_not_empty),
        .count_o     (fifo_count)
    );

    fx2_usb_pipe u_pipe (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_i        (fifo_rd_data),
        .data_avail_i  (fifo_not_empty),
        .read_strobe_o (fifo_rd_strobe),
        .ready_i       (ready_i),
        .slwr_n_o      (slwr_n_o),
        .fd_o          (fd_o),
        .fd_oe_o       (fd_oe_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status is the verdict

cd "$(dirname "$0")" &&
verilator --binary --timing \
    --top-module tb_usb_tx \
    -f usb_tx_top.f \
    -o tb_usb_tx &&
./obj_dir/tb_usb_tx ||
{
    echo "simulation build or run failed"
    exit 1
}

//--- sim/fx2_fifo_model.sv
// fx2 endpoint model: room flag from random bits or a stall, capture queue of written bytes

`timescale 1ns/1ps

module fx2_fifo_model (
    input  logic       clk_i,         // fx2 interface clock
    input  logic       stall_i,       // hold the room flag low
    input  logic       rand_ready_i,  // random room pattern from the testbench
    input  logic       slwr_n_i,      // write strobe from the dut
    input  logic [7:0] fd_i,          // data bus from the dut
    output logic       ready_o        // room in the endpoint
);

    //////////////////////////////////////////////////
    // endpoint state
    //////////////////////////////////////////////////

    logic [7:0] captured_q [$];       // bytes taken, oldest first

    // no room while stalled, otherwise follow the random pattern
    assign ready_o = rand_ready_i && !stall_i;

    // the endpoint latches the bus at the rising edge that ends a write cycle
    always @(posedge clk_i) begin
        if (!slwr_n_i) begin
            captured_q.push_back(fd_i);   // keep for the testbench to compare
        end
    end

endmodule

//--- sim/tb_usb_tx.sv
// testbench for the usb transmit path with clock, reset, lfsr stimulus, reference queue and checks

`timescale 1ns/1ps

module tb_usb_tx;

    import usb_tx_pkg::*;

    localparam logic [31:0] LFSR_SEED  = 32'h9b58_3ade;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
    localparam int          N_SAMPLES  = 200;
    localparam int          ROOM_LIMIT = 14;              // outstanding bytes allowed at a send
    localparam int          IN_FLIGHT  = FIFO_DEPTH + 1;  // fifo plus its read register
    localparam int          TIMEOUT    = 2000;            // cycles per wait
    localparam int          QUIET      = 100;             // idle window after a drain

    logic        clk;
    logic        rst_n;
    logic        sample_valid;
    sample_u     sample;
    logic        overflow;
    logic        ready;
    logic        slwr_n;
    byte_t       fd;
    logic        fd_oe;
    logic        stall;         // endpoint full on request
    logic        rand_ready;    // random room bit for the model
    logic [31:0] lfsr_state;
    logic [7:0]  ref_q [$];     // bytes expected on the fx2 bus in order
    logic        prev_write;    // slwr_n was low last cycle
    int          write_count;   // fx2 writes seen by the bus monitor

    usb_tx_top DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .sample_valid_i (sample_valid),
        .sample_i       (sample),
        .overflow_o     (overflow),
        .ready_i        (ready),
        .slwr_n_o       (slwr_n),
        .fd_o           (fd),
        .fd_oe_o        (fd_oe)
    );

    fx2_fifo_model u_fx2 (
        .clk_i        (clk),
        .stall_i      (stall),
        .rand_ready_i (rand_ready),
        .slwr_n_i     (slwr_n),
        .fd_i         (fd),
        .ready_o      (ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    //////////////////////////////////////////////////
    // reporting and random bits
    //////////////////////////////////////////////////

    task automatic report_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            report_failure();
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;   // galois feedback
        end
        return s >> 1;
    endfunction

    task automatic get_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);   // one step per bit
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // cycle stepping and stimulus
    //////////////////////////////////////////////////

    // compare every byte the endpoint took against the reference queue
    task automatic drain_captured();
        logic [7:0] got;
        while (u_fx2.captured_q.size() > 0) begin
            got = u_fx2.captured_q.pop_front();
            if (ref_q.size() == 0) begin
                $display("the FX2 took byte %0h at %0t while no byte was expected", got, $time);
                report_failure();
            end else begin
                check_value("fd_o", 32'(got), 32'(ref_q.pop_front()));
            end
        end
    endtask

    task automatic next_cycle();
        logic [15:0] bits;
        @(negedge clk);
        get_bits(2, bits);
        rand_ready = |bits[1:0];   // room three quarters of the time
        drain_captured();
    endtask

    task automatic wait_for_room();
        int cycles;
        cycles = 0;
        while (ref_q.size() > ROOM_LIMIT) begin
            if (cycles == TIMEOUT) begin
                $display("timeout at %0t: outstanding bytes never fell to the send limit", $time);
                report_failure();
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (ref_q.size() != 0) begin
            if (cycles == TIMEOUT) begin
                $display("timeout at %0t: %0d expected bytes never reached the FX2",
                         $time, ref_q.size());
                report_failure();
            end
            next_cycle();
            cycles++;
        end
    endtask

    // one cycle strobe with the high byte expected first
    task automatic send_sample(input logic [15:0] word, input logic accepted);
        sample.value = $signed(word);
        sample_valid = 1'b1;
        if (accepted) begin
            ref_q.push_back(word[15:8]);
            ref_q.push_back(word[7:0]);
        end
        next_cycle();
        sample_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // bus monitor sampling values just before each rising edge
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            check_value("fd_oe_o", 32'(fd_oe), 32'(!slwr_n));
            if (!slwr_n) begin
                check_value("ready_i", 32'(ready), 32'd1);     // write only into room
                if (prev_write) begin
                    check_value("slwr_n_o", 32'(slwr_n), 32'd1);  // single cycle strobe
                end
                write_count++;
            end else begin
                check_value("fd_o", 32'(fd), 32'd0);           // quiet bus when idle
            end
            prev_write = !slwr_n;
        end else begin
            prev_write = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // scenarios
    //////////////////////////////////////////////////

    initial begin
        logic [15:0] word;
        logic [15:0] gap;
        logic        accept;
        logic        sticky;       // expected overflow flag
        int          writes_before;
        int          bytes_expected;

        lfsr_state   = LFSR_SEED;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        stall        = 1'b1;
        rand_ready   = 1'b0;
        write_count  = 0;
        prev_write   = 1'b0;

        repeat (10) next_cycle();   // reset held for 10 cycles
        rst_n = 1'b1;
        stall = 1'b0;               // endpoint room follows the random pattern

        // state right after reset
        repeat (5) begin
            next_cycle();
            check_value("slwr_n_o", 32'(slwr_n), 32'd1);
            check_value("fd_oe_o", 32'(fd_oe), 32'd0);
            check_value("overflow_o", 32'(overflow), 32'd0);
        end

        // random samples and gaps against a random room flag
        for (int i = 0; i < N_SAMPLES; i++) begin
            wait_for_room();
            get_bits(16, word);
            send_sample(word, 1'b1);
            get_bits(3, gap);
            repeat (int'(gap) + 1) next_cycle();   // strobes at least two cycles apart
        end
        wait_for_drain();
        check_value("overflow_o", 32'(overflow), 32'd0);

        // endpoint full so the fifo fills and later samples are dropped
        stall          = 1'b1;
        writes_before  = write_count;
        bytes_expected = 0;
        sticky         = 1'b0;
        for (int i = 0; i < 10; i++) begin
            get_bits(16, word);
            accept = ref_q.size() + 2 <= IN_FLIGHT;
            sticky = sticky || !accept;
            if (accept) begin
                bytes_expected += 2;
            end
            send_sample(word, accept);
            check_value("overflow_o", 32'(overflow), 32'(sticky));
            repeat (2) next_cycle();   // three cycles per sample
        end
        check_value("slwr_n_o write count", 32'(write_count - writes_before), 32'd0);

        stall = 1'b0;
        wait_for_drain();
        repeat (QUIET) next_cycle();   // nothing more may follow
        check_value("slwr_n_o write count", 32'(write_count - writes_before),
                    32'(bytes_expected));

        $display("No errors");
        $finish;
    end

endmodule

//--- usb_tx_top.f
hdl/usb_tx_pkg.sv
hdl/sample_packer.sv
hdl/byte_fifo.sv
hdl/fx2_usb_pipe.sv
hdl/usb_tx_top.sv
sim/fx2_fifo_model.sv
sim/tb_usb_tx.sv
